// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of tb_snake_top, run from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_snake_top -Mdir obj_dir -f snake_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_snake_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
    exit 1
fi
exit 0

// ==== snake_top.f ====
verilog/game_pkg.sv
verilog/bus_pkg.sv
verilog/snake_regs.sv
verilog/game_ctrl.sv
verilog/snake_body.sv
verilog/food_gen.sv
verilog/raster_scan.sv
verilog/pixel_shader.sv
verilog/snake_top.sv
tests/clk_gen.sv
tests/tb_snake_top.sv

// ==== tests/clk_gen.sv ====
module clk_gen (
    output logic CLK,
    output logic RESET
);
    initial begin
        CLK = 1'b0;
        forever #10 CLK = !CLK;
    end

    // held for four rising edges, released just after the fourth
    initial begin
        RESET = 1'b1;
        repeat (4) @(posedge CLK);
        #2;
        RESET = 1'b0;
    end

endmodule

// ==== tests/snake_tests.dat ====
# command and args: write/expect ADDR DATA, badaddr ADDR, press MASK, track COL ROW (hex)
# wait/moves COUNT (decimal), pixel X Y RGB (x y decimal), mask bits: left right up down
# reset values
expect 0c 00000500
expect 04 00001000
badaddr 1c
badaddr 3c
# seed 07a2 steps to 03d1, food at col 17 row 6
write 08 000007a2
write 04 00000040
write 00 00000001
press 2
release
expect 0c 00000501
expect 14 00000611
moves 2
track 0c 0c
# five steps right, then up onto the food
moves 5
press 4
release
moves 11
write 04 0000ffff
expect 0c 00000601
expect 14 00000f08
expect 10 00000611
# head, body, masked tail cell, food, border
pixel 34 12 0f0
pixel 34 20 0f0
pixel 34 24 000
pixel 16 30 f00
pixel 0 0 fff
# up into the top wall
write 04 00000040
press 4
wait 600
release
expect 0c 00000602
expect 10 00000011
expect 18 00000011
write 00 00000003
expect 0c 00000600
expect 00 00000001

// ==== tests/tb_snake_top.sv ====
module tb_snake_top;
    import bus_pkg::*;

    // small raster so a frame is only a few thousand cycles
    localparam int MAX_LEN  = 10;
    localparam int CELL_PX  = 2;
    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 4;
    localparam int V_ACTIVE = 48;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 2;
    localparam int FRAME = (H_ACTIVE + H_FRONT + H_SYNC + H_BACK)
                         * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
    localparam int MARGIN = 2000;
    localparam string DATA_FILE = "tests/snake_tests.dat";

    logic CLK;
    logic RESET;
    logic [ADDR_W-1:0] s_axi_awaddr;
    logic s_axi_awvalid;
    logic s_axi_awready;
    logic [DATA_W-1:0] s_axi_wdata;
    logic s_axi_wvalid;
    logic s_axi_wready;
    logic [1:0] s_axi_bresp;
    logic s_axi_bvalid;
    logic s_axi_bready;
    logic [ADDR_W-1:0] s_axi_araddr;
    logic s_axi_arvalid;
    logic s_axi_arready;
    logic [DATA_W-1:0] s_axi_rdata;
    logic [1:0] s_axi_rresp;
    logic s_axi_rvalid;
    logic s_axi_rready;
    logic btn_left;
    logic btn_right;
    logic btn_up;
    logic btn_down;
    logic hsync;
    logic vsync;
    logic [11:0] rgb;

    int errors;
    int checks;
    int limit;

    clk_gen clk0 (.CLK(CLK), .RESET(RESET));

    snake_top #(
        .MAX_LEN (MAX_LEN),
        .CELL_PX (CELL_PX),
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK)
    ) dut0 (.*);

    task automatic drive_slot();
        @(posedge CLK);
        #2;
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        drive_slot();
        s_axi_awaddr = addr;
        s_axi_wdata = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid = 1'b1;
        @(negedge CLK);
        while (!s_axi_awready) @(negedge CLK);
        // address and data are taken in the same cycle
        check("wready", 32'(s_axi_wready), 32'h1);
        drive_slot();
        s_axi_awvalid = 1'b0;
        s_axi_wvalid = 1'b0;
        @(negedge CLK);
        while (!s_axi_bvalid) @(negedge CLK);
        resp = s_axi_bresp;
    endtask

    task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        drive_slot();
        s_axi_araddr = addr;
        s_axi_arvalid = 1'b1;
        @(negedge CLK);
        while (!s_axi_arready) @(negedge CLK);
        drive_slot();
        s_axi_arvalid = 1'b0;
        @(negedge CLK);
        while (!s_axi_rvalid) @(negedge CLK);
        data = s_axi_rdata;
        resp = s_axi_rresp;
    endtask

    // frame start is the rising vsync, each line ends with a rising hsync
    task automatic sample_pixel(input int x, input int y, output logic [11:0] value);
        logic prev;
        int k;
        @(negedge CLK);
        prev = vsync;
        @(negedge CLK);
        while (!(vsync && !prev)) begin
            prev = vsync;
            @(negedge CLK);
        end
        for (k = 0; k < V_BACK + y; k++) begin
            prev = hsync;
            @(negedge CLK);
            while (!(hsync && !prev)) begin
                prev = hsync;
                @(negedge CLK);
            end
        end
        repeat (H_BACK + x) @(negedge CLK);
        value = rgb;
    endtask

    // one command and its arguments, comment lines start with "# "
    task automatic read_cmd(input int fd, output logic [63:0] cmd, output logic [31:0] a,
                            output logic [31:0] b, output logic [31:0] c, output bit ok);
        logic [8*96-1:0] rest;
        int n;
        ok = 1'b0;
        a = '0;
        b = '0;
        c = '0;
        cmd = '0;
        n = $fscanf(fd, "%s", cmd);
        while (n == 1 && cmd == "#") begin
            n = $fgets(rest, fd);
            n = $fscanf(fd, "%s", cmd);
        end
        if (n != 1) return;
        ok = 1'b1;
        case (cmd)
            "write", "expect", "track": n = $fscanf(fd, "%h %h", a, b);
            "badaddr", "press":         n = $fscanf(fd, "%h", a);
            "wait", "moves":            n = $fscanf(fd, "%d", a);
            "pixel":                    n = $fscanf(fd, "%d %d %h", a, b, c);
            default:                    n = 0;
        endcase
    endtask

    task automatic run_cmd(input logic [63:0] cmd, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] c);
        logic [31:0] data;
        logic [31:0] m_before;
        logic [31:0] m_after;
        logic [1:0] resp;
        logic [11:0] pix;
        int tries;
        case (cmd)
            "write": begin
                axi_write(ADDR_W'(a), b, resp);
                check("bresp", 32'(resp), 32'(RESP_OKAY));
            end
            "expect": begin
                axi_read(ADDR_W'(a), data, resp);
                check("rresp", 32'(resp), 32'(RESP_OKAY));
                check($sformatf("rdata[%02h]", a[7:0]), data, b);
            end
            "badaddr": begin
                axi_read(ADDR_W'(a), data, resp);
                check("rresp", 32'(resp), 32'(RESP_SLVERR));
            end
            "press": begin
                drive_slot();
                {btn_down, btn_up, btn_right, btn_left} = a[3:0];
            end
            "release": begin
                drive_slot();
                {btn_down, btn_up, btn_right, btn_left} = 4'b0000;
            end
            "wait": repeat (int'(a)) @(posedge CLK);
            "moves": begin
                data = '0;
                while (data < a) axi_read(REG_MOVES, data, resp);
            end
            "track": begin
                // a step landing between the reads forces another try
                tries = 0;
                do begin
                    axi_read(REG_MOVES, m_before, resp);
                    axi_read(REG_HEAD, data, resp);
                    axi_read(REG_MOVES, m_after, resp);
                    tries++;
                end while (m_before != m_after && tries < 4);
                check("head", data, (b << 8) | (a + m_before));
            end
            "pixel": begin
                sample_pixel(int'(a), int'(b), pix);
                check("rgb", {20'h0, pix}, c);
            end
            default: begin
                errors++;
                $display("unknown command %s in %s", cmd, DATA_FILE);
            end
        endcase
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (limit != 0);
        while (cycles < limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", limit);
        $display("checks %0d, errors %0d", checks, errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int fd;
        int budget;
        logic [63:0] cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        bit ok;
        errors = 0;
        checks = 0;
        limit = 0;
        s_axi_awaddr = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_wvalid = 1'b0;
        s_axi_bready = 1'b1;
        s_axi_araddr = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b1;
        {btn_down, btn_up, btn_right, btn_left} = 4'b0000;
        void'($urandom(32'h5882));
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open %s", DATA_FILE);
        end else begin
            // first pass only sizes the timeout
            budget = MARGIN;
            read_cmd(fd, cmd, a, b, c, ok);
            while (ok) begin
                if (cmd == "wait") budget += int'(a);
                if (cmd == "pixel") budget += 2 * FRAME;
                read_cmd(fd, cmd, a, b, c, ok);
            end
            $fclose(fd);
            limit = budget;
            fd = $fopen(DATA_FILE, "r");
            wait (RESET === 1'b0);
            read_cmd(fd, cmd, a, b, c, ok);
            while (ok) begin
                run_cmd(cmd, a, b, c);
                repeat ($urandom % 4) @(posedge CLK);
                read_cmd(fd, cmd, a, b, c, ok);
            end
            $fclose(fd);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog/bus_pkg.sv ====
package bus_pkg;

    localparam int ADDR_W = 6;
    localparam int DATA_W = 32;

    localparam logic [ADDR_W-1:0] REG_CTRL   = 6'h00;
    localparam logic [ADDR_W-1:0] REG_PERIOD = 6'h04;
    localparam logic [ADDR_W-1:0] REG_SEED   = 6'h08;
    localparam logic [ADDR_W-1:0] REG_STATUS = 6'h0C;
    localparam logic [ADDR_W-1:0] REG_HEAD   = 6'h10;
    localparam logic [ADDR_W-1:0] REG_FOOD   = 6'h14;
    // last register in the map
    localparam logic [ADDR_W-1:0] REG_MOVES  = 6'h18;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== verilog/food_gen.sv ====
module food_gen (
    input  logic           CLK,
    input  logic           RESET,
    input  logic [15:0]    seed,
    input  logic           start,
    input  logic           eaten,
    output game_pkg::col_t food_col,
    output game_pkg::row_t food_row
);
    import game_pkg::*;

    logic [15:0] lfsr;
    logic [15:0] seed_nz;

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] v);
        return {1'b0, v[15:1]} ^ (v[0] ? 16'hB400 : 16'h0000);
    endfunction

    // all-zero state would lock up
    assign seed_nz = (seed == 16'h0000) ? 16'h0001 : seed;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            lfsr <= 16'h0001;
        end else if (start) begin
            lfsr <= lfsr_step(seed_nz);
        end else if (eaten) begin
            lfsr <= lfsr_step(lfsr);
        end
    end

    assign food_col = lfsr[4:0];
    assign food_row = (lfsr[9:5] >= 5'(GRID_ROWS)) ? lfsr[9:5] - 5'(GRID_ROWS)
                                                   : lfsr[9:5];

endmodule

// ==== verilog/game_ctrl.sv ====
module game_ctrl (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  run,
    input  logic                  restart,
    input  logic [15:0]           step_period,
    input  logic                  btn_left,
    input  logic                  btn_right,
    input  logic                  btn_up,
    input  logic                  btn_down,
    input  game_pkg::col_t        head_col,
    input  game_pkg::row_t        head_row,
    output game_pkg::game_state_t state,
    output logic                  start,
    output logic                  advance,
    output game_pkg::col_t        next_col,
    output game_pkg::row_t        next_row
);
    import game_pkg::*;

    dir_t dir;
    dir_t want;
    logic [15:0] step_cnt;
    logic [5:0] nx;
    logic [5:0] ny;
    logic any_btn;
    logic step_due;
    logic wall;

    assign any_btn = btn_left | btn_right | btn_up | btn_down;

    always_comb begin
        if (btn_left) begin
            want = DIR_LEFT;
        end else if (btn_right) begin
            want = DIR_RIGHT;
        end else if (btn_up) begin
            want = DIR_UP;
        end else if (btn_down) begin
            want = DIR_DOWN;
        end else begin
            want = dir;
        end
    end

    always_comb begin
        nx = {1'b0, head_col};
        ny = {1'b0, head_row};
        case (dir)
            DIR_RIGHT: nx = nx + 6'd1;
            DIR_LEFT:  nx = nx - 6'd1;
            DIR_UP:    ny = ny - 6'd1;
            default:   ny = ny + 6'd1;
        endcase
    end

    // leaving row 0 or column 0 wraps to 63 and fails the same compare
    assign wall = (nx >= 6'(GRID_COLS)) || (ny >= 6'(GRID_ROWS));
    assign next_col = nx[4:0];
    assign next_row = ny[4:0];
    assign step_due = (state == ST_PLAY) && !start && (step_cnt >= step_period);
    assign advance = step_due && !wall;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= ST_IDLE;
            start <= 1'b0;
            dir <= DIR_RIGHT;
            step_cnt <= 16'd0;
        end else begin
            start <= 1'b0;
            step_cnt <= step_cnt + 16'd1;
            if (restart) begin
                state <= ST_IDLE;
            end else if (state == ST_IDLE && run && any_btn) begin
                state <= ST_PLAY;
                start <= 1'b1;
            end else if (step_due && wall) begin
                state <= ST_OVER;
            end
            if (start) begin
                dir <= DIR_RIGHT;
                step_cnt <= 16'd1;
            end else begin
                if (step_due) begin
                    step_cnt <= 16'd1;
                end
                // no u-turn onto the neck
                if (state == ST_PLAY && want != dir_t'(dir ^ 2'b01)) begin
                    dir <= want;
                end
            end
        end
    end

    // never in the entry cycle, never outside a game
    assert property (@(posedge CLK) disable iff (RESET)
        advance |-> state == ST_PLAY && $past(state) == ST_PLAY);

endmodule

// ==== verilog/game_pkg.sv ====
package game_pkg;

    localparam int GRID_COLS = 32;
    localparam int GRID_ROWS = 24;
    localparam int LEN_W = 4;

    typedef logic [4:0] col_t;
    typedef logic [4:0] row_t;
    typedef logic [11:0] rgb_t;

    // opposite headings differ only in bit 0
    typedef enum logic [1:0] {
        DIR_RIGHT = 2'd0,
        DIR_LEFT  = 2'd1,
        DIR_UP    = 2'd2,
        DIR_DOWN  = 2'd3
    } dir_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_PLAY = 2'd1,
        ST_OVER = 2'd2
    } game_state_t;

    localparam logic [LEN_W-1:0] START_LEN = 4'd5;
    localparam col_t START_COL = 5'd12;
    localparam row_t START_ROW = 5'd12;

    // 4 bits per channel, r g b
    localparam rgb_t RGB_SNAKE = 12'h0F0;
    localparam rgb_t RGB_FOOD  = 12'hF00;
    localparam rgb_t RGB_ARENA = 12'h000;
    localparam rgb_t RGB_WHITE = 12'hFFF;

endpackage

// ==== verilog/pixel_shader.sv ====
module pixel_shader #(
    parameter int MAX_LEN = 10,
    parameter int CELL_PX = 25
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  game_pkg::game_state_t state,
    input  logic [10:0]           px_x,
    input  logic [10:0]           px_y,
    input  logic                  active,
    input  logic                  hs,
    input  logic                  vs,
    input  game_pkg::col_t        seg_col [MAX_LEN],
    input  game_pkg::row_t        seg_row [MAX_LEN],
    input  logic [MAX_LEN-1:0]    seg_valid,
    input  game_pkg::col_t        food_col,
    input  game_pkg::row_t        food_row,
    output logic                  hsync,
    output logic                  vsync,
    output game_pkg::rgb_t        rgb
);
    import game_pkg::*;

    col_t cell_col;
    row_t cell_row;
    logic on_snake;
    logic on_food;
    logic on_border;
    rgb_t colour;

    assign cell_col = col_t'(px_x / 11'(CELL_PX));
    assign cell_row = row_t'(px_y / 11'(CELL_PX));

    always_comb begin
        on_snake = 1'b0;
        for (int i = 0; i < MAX_LEN; i++) begin
            if (seg_valid[i] && seg_col[i] == cell_col && seg_row[i] == cell_row) begin
                on_snake = 1'b1;
            end
        end
    end

    assign on_food = (cell_col == food_col) && (cell_row == food_row);
    assign on_border = (cell_col == 5'd0) || (cell_col == col_t'(GRID_COLS - 1))
                    || (cell_row == 5'd0) || (cell_row == row_t'(GRID_ROWS - 1));

    always_comb begin
        if (!active) begin
            colour = '0;
        end else if (state != ST_PLAY) begin
            colour = RGB_WHITE;
        end else if (on_snake) begin
            colour = RGB_SNAKE;
        end else if (on_food) begin
            colour = RGB_FOOD;
        end else if (on_border) begin
            colour = RGB_WHITE;
        end else begin
            colour = RGB_ARENA;
        end
    end

    // syncs ride along with the colour register
    always_ff @(posedge CLK) begin
        if (RESET) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            rgb <= '0;
        end else begin
            hsync <= hs;
            vsync <= vs;
            rgb <= colour;
        end
    end

endmodule

// ==== verilog/raster_scan.sv ====
module raster_scan #(
    parameter int H_ACTIVE = 800,
    parameter int H_FRONT  = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BACK   = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BACK   = 23
) (
    input  logic        CLK,
    input  logic        RESET,
    output logic [10:0] px_x,
    output logic [10:0] px_y,
    output logic        active,
    output logic        hs,
    output logic        vs
);
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_BEGIN = H_ACTIVE + H_FRONT;
    localparam int VS_BEGIN = V_ACTIVE + V_FRONT;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            px_x <= 11'd0;
            px_y <= 11'd0;
        end else if (px_x == 11'(H_TOTAL - 1)) begin
            px_x <= 11'd0;
            px_y <= (px_y == 11'(V_TOTAL - 1)) ? 11'd0 : px_y + 11'd1;
        end else begin
            px_x <= px_x + 11'd1;
        end
    end

    assign active = (px_x < 11'(H_ACTIVE)) && (px_y < 11'(V_ACTIVE));

    // both syncs pulse low
    assign hs = !((px_x >= 11'(HS_BEGIN)) && (px_x < 11'(HS_BEGIN + H_SYNC)));
    assign vs = !((px_y >= 11'(VS_BEGIN)) && (px_y < 11'(VS_BEGIN + V_SYNC)));

endmodule

// ==== verilog/snake_body.sv ====
module snake_body #(
    parameter int MAX_LEN = 10
) (
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic                       start,
    input  logic                       advance,
    input  game_pkg::col_t             next_col,
    input  game_pkg::row_t             next_row,
    input  game_pkg::col_t             food_col,
    input  game_pkg::row_t             food_row,
    output game_pkg::col_t             head_col,
    output game_pkg::row_t             head_row,
    output game_pkg::col_t             seg_col [MAX_LEN],
    output game_pkg::row_t             seg_row [MAX_LEN],
    output logic [MAX_LEN-1:0]         seg_valid,
    output logic [game_pkg::LEN_W-1:0] length,
    output logic                       eaten,
    output logic [15:0]                moves
);
    import game_pkg::*;

    logic on_food;

    assign on_food = (next_col == food_col) && (next_row == food_row);
    assign head_col = seg_col[0];
    assign head_row = seg_row[0];

    always_comb begin
        for (int i = 0; i < MAX_LEN; i++) begin
            seg_valid[i] = i < int'(length);
        end
    end

    // tail segments keep shifting so growth just uncovers the next one
    always_ff @(posedge CLK) begin
        if (RESET || start) begin
            for (int i = 0; i < MAX_LEN; i++) begin
                seg_col[i] <= col_t'(int'(START_COL) - i);
                seg_row[i] <= START_ROW;
            end
        end else if (advance) begin
            seg_col[0] <= next_col;
            seg_row[0] <= next_row;
            for (int i = 1; i < MAX_LEN; i++) begin
                seg_col[i] <= seg_col[i-1];
                seg_row[i] <= seg_row[i-1];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET || start) begin
            length <= START_LEN;
            moves <= 16'd0;
            eaten <= 1'b0;
        end else begin
            eaten <= advance && on_food;
            if (advance) begin
                moves <= moves + 16'd1;
            end
            if (advance && on_food && length < LEN_W'(MAX_LEN)) begin
                length <= length + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/snake_regs.sv ====
module snake_regs (
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic [bus_pkg::ADDR_W-1:0] s_axi_awaddr,
    input  logic                       s_axi_awvalid,
    output logic                       s_axi_awready,
    input  logic [bus_pkg::DATA_W-1:0] s_axi_wdata,
    input  logic                       s_axi_wvalid,
    output logic                       s_axi_wready,
    output logic [1:0]                 s_axi_bresp,
    output logic                       s_axi_bvalid,
    input  logic                       s_axi_bready,
    input  logic [bus_pkg::ADDR_W-1:0] s_axi_araddr,
    input  logic                       s_axi_arvalid,
    output logic                       s_axi_arready,
    output logic [bus_pkg::DATA_W-1:0] s_axi_rdata,
    output logic [1:0]                 s_axi_rresp,
    output logic                       s_axi_rvalid,
    input  logic                       s_axi_rready,
    input  game_pkg::game_state_t      state,
    input  logic [game_pkg::LEN_W-1:0] length,
    input  game_pkg::col_t             head_col,
    input  game_pkg::row_t             head_row,
    input  game_pkg::col_t             food_col,
    input  game_pkg::row_t             food_row,
    input  logic [15:0]                moves,
    output logic                       run,
    output logic                       restart,
    output logic [15:0]                step_period,
    output logic [15:0]                seed
);
    import bus_pkg::*;

    logic idle;
    logic wr_fire;
    logic rd_fire;
    logic [DATA_W-1:0] rd_word;

    function automatic logic mapped(input logic [ADDR_W-1:0] addr);
        return (addr <= REG_MOVES) && (addr[1:0] == 2'b00);
    endfunction

    // nothing new is taken while a response is still pending
    assign idle = !s_axi_awready && !s_axi_arready && !s_axi_bvalid && !s_axi_rvalid;
    assign s_axi_wready = s_axi_awready;
    assign wr_fire = s_axi_awready && s_axi_awvalid && s_axi_wvalid;
    assign rd_fire = s_axi_arready && s_axi_arvalid;

    always_comb begin
        case (s_axi_araddr)
            REG_CTRL:   rd_word = DATA_W'(run);
            REG_PERIOD: rd_word = DATA_W'(step_period);
            REG_SEED:   rd_word = DATA_W'(seed);
            REG_STATUS: rd_word = DATA_W'({length, 6'b0, state});
            REG_HEAD:   rd_word = DATA_W'({head_row, 3'b0, head_col});
            REG_FOOD:   rd_word = DATA_W'({food_row, 3'b0, food_col});
            REG_MOVES:  rd_word = DATA_W'(moves);
            default:    rd_word = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            s_axi_awready <= 1'b0;
            s_axi_arready <= 1'b0;
            s_axi_bvalid <= 1'b0;
            s_axi_rvalid <= 1'b0;
            run <= 1'b0;
            restart <= 1'b0;
            step_period <= 16'h1000;
            seed <= 16'h0001;
        end else begin
            restart <= 1'b0;
            // writes win when both channels arrive together
            s_axi_awready <= idle && s_axi_awvalid && s_axi_wvalid;
            s_axi_arready <= idle && s_axi_arvalid && !(s_axi_awvalid && s_axi_wvalid);
            if (wr_fire) begin
                s_axi_bvalid <= 1'b1;
                case (s_axi_awaddr)
                    REG_CTRL: begin
                        run <= s_axi_wdata[0];
                        restart <= s_axi_wdata[1];
                    end
                    REG_PERIOD: step_period <= s_axi_wdata[15:0];
                    REG_SEED:   seed <= s_axi_wdata[15:0];
                    default:    ;
                endcase
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
            if (rd_fire) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_fire) begin
            s_axi_bresp <= mapped(s_axi_awaddr) ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_fire) begin
            s_axi_rdata <= rd_word;
            s_axi_rresp <= mapped(s_axi_araddr) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assert property (@(posedge CLK) disable iff (RESET)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

endmodule

// ==== verilog/snake_top.sv ====
module snake_top #(
    parameter int MAX_LEN  = 10,
    parameter int CELL_PX  = 25,
    parameter int H_ACTIVE = 800,
    parameter int H_FRONT  = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BACK   = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BACK   = 23
) (
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic [bus_pkg::ADDR_W-1:0] s_axi_awaddr,
    input  logic                       s_axi_awvalid,
    output logic                       s_axi_awready,
    input  logic [bus_pkg::DATA_W-1:0] s_axi_wdata,
    input  logic                       s_axi_wvalid,
    output logic                       s_axi_wready,
    output logic [1:0]                 s_axi_bresp,
    output logic                       s_axi_bvalid,
    input  logic                       s_axi_bready,
    input  logic [bus_pkg::ADDR_W-1:0] s_axi_araddr,
    input  logic                       s_axi_arvalid,
    output logic                       s_axi_arready,
    output logic [bus_pkg::DATA_W-1:0] s_axi_rdata,
    output logic [1:0]                 s_axi_rresp,
    output logic                       s_axi_rvalid,
    input  logic                       s_axi_rready,
    input  logic                       btn_left,
    input  logic                       btn_right,
    input  logic                       btn_up,
    input  logic                       btn_down,
    output logic                       hsync,
    output logic                       vsync,
    output game_pkg::rgb_t             rgb
);
    import game_pkg::*;

    logic run;
    logic restart;
    logic [15:0] step_period;
    logic [15:0] seed;
    game_state_t state;
    logic start;
    logic advance;
    col_t next_col;
    row_t next_row;
    col_t head_col;
    row_t head_row;
    col_t seg_col [MAX_LEN];
    row_t seg_row [MAX_LEN];
    logic [MAX_LEN-1:0] seg_valid;
    logic [LEN_W-1:0] length;
    logic eaten;
    logic [15:0] moves;
    col_t food_col;
    row_t food_row;
    logic [10:0] px_x;
    logic [10:0] px_y;
    logic active;
    logic hs;
    logic vs;

    // every port below matches a wire or top-level port by name
    snake_regs regs0 (.*);

    game_ctrl ctrl0 (.*);

    snake_body #(.MAX_LEN(MAX_LEN)) body0 (.*);

    food_gen food0 (.*);

    raster_scan #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK)
    ) scan0 (.*);

    pixel_shader #(
        .MAX_LEN(MAX_LEN),
        .CELL_PX(CELL_PX)
    ) shade0 (.*);

endmodule
